// ==== logic/data_way.sv ====
`timescale 1ns/1ps

module data_way import llc_pkg::*; (
  input logic clk_i,
  input logic arst_n_i,
  way_if.array way_i
);

  logic [DATA_W-1:0] mem_q [NUM_WAYS][NUM_SETS][NUM_BLOCKS];  // line storage
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  // single port, never busy
  assign way_i.gnt    = way_i.req;
  assign way_i.rvalid = rvalid_q;
  assign way_i.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // array starts out all zero
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          for (int b = 0; b < NUM_BLOCKS; b++) begin
            mem_q[w][s][b] <= '0;
          end
        end
      end
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= way_i.req & ~way_i.we;  // read answer next cycle
      if (way_i.req && way_i.we) begin
        mem_q[way_i.way][way_i.set][way_i.blk] <= way_i.wdata;
      end
    end
  end

  // registered read port
  always_ff @(posedge clk_i) begin
    if (way_i.req && !way_i.we) begin
      rdata_q <= mem_q[way_i.way][way_i.set][way_i.blk];
    end
  end

endmodule

// ==== logic/evict_unit.sv ====
`timescale 1ns/1ps

module evict_unit import llc_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // descriptor in
  input  desc_t             desc_i,
  input  logic              desc_valid_i,
  output logic              desc_ready_o,
  // descriptor out, towards the hit unit
  output desc_t             desc_o,
  output logic              desc_valid_o,
  input  logic              desc_ready_i,
  // data array reads
  way_if.requester          way_o,
  // AXI4-Lite write master
  output logic [ADDR_W-1:0] awaddr_o,
  output logic              awvalid_o,
  input  logic              awready_i,
  output logic [DATA_W-1:0] wdata_o,
  output logic [DATA_W/8-1:0] wstrb_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  logic              bvalid_i,
  output logic              bready_o,
  // flush descriptor destroyed
  output logic              flush_done_o
);

  evict_state_e      state_q, state_d;
  desc_t             desc_q;                   // descriptor held by the unit
  logic              take_desc;                // descriptor handshake on the input
  logic              load_cnt;                 // eviction starts, clear the counters
  logic [BLK_W:0]    req_cnt_q;                // array reads issued so far
  logic [BLK_W-1:0]  wr_cnt_q;                 // block being written to memory
  logic [BLK_W-1:0]  resp_cnt_q;               // B responses seen so far
  logic              aw_done_q, w_done_q;      // channel already handshaked for this block
  logic              aw_hs, w_hs, b_hs;
  logic              blk_done;                 // both channels done for the head block
  // line buffer
  logic [DATA_W-1:0] fifo_q [NUM_BLOCKS];
  logic [BLK_W-1:0]  push_ptr_q, pop_ptr_q;
  logic [BLK_W:0]    fifo_cnt_q;
  logic              fifo_empty, fifo_push, fifo_pop;

  assign take_desc = desc_ready_o & desc_valid_i;
  assign load_cnt  = take_desc & (desc_i.op == OP_EVICT);
  assign desc_o    = desc_q;

  // array side, read only, block offset from the request counter
  assign way_o.req   = (state_q == EV_EVICT) & (req_cnt_q != (BLK_W+1)'(NUM_BLOCKS));
  assign way_o.we    = 1'b0;
  assign way_o.way   = desc_q.way;
  assign way_o.set   = desc_q.set;
  assign way_o.blk   = req_cnt_q[BLK_W-1:0];
  assign way_o.wdata = '0;

  // buffer sized for a whole line so read data is always taken
  assign fifo_empty = (fifo_cnt_q == '0);
  assign fifo_push  = way_o.rvalid;
  assign fifo_pop   = blk_done;

  // AW and W raised together per block, each drops on its own handshake
  assign awvalid_o = (state_q == EV_EVICT) & ~fifo_empty & ~aw_done_q;
  assign wvalid_o  = (state_q == EV_EVICT) & ~fifo_empty & ~w_done_q;
  assign awaddr_o  = desc_q.line_addr + {{(ADDR_W-BLK_W-2){1'b0}}, wr_cnt_q, 2'b00};
  assign wdata_o   = fifo_q[pop_ptr_q];
  assign wstrb_o   = '1;                       // full word writes only
  assign bready_o  = (state_q == EV_EVICT) | (state_q == EV_RESP);

  assign aw_hs    = awvalid_o & awready_i;
  assign w_hs     = wvalid_o & wready_i;
  assign b_hs     = bvalid_i & bready_o;       // response code ignored
  assign blk_done = ~fifo_empty & (aw_done_q | aw_hs) & (w_done_q | w_hs);

  always_comb begin
    state_d      = state_q;
    desc_ready_o = 1'b0;
    desc_valid_o = 1'b0;
    flush_done_o = 1'b0;
    case (state_q)
      EV_IDLE: desc_ready_o = 1'b1;
      EV_EVICT: begin
        if (blk_done && wr_cnt_q == BLK_W'(NUM_BLOCKS-1)) state_d = EV_RESP;  // last block out
      end
      EV_RESP: begin
        if (b_hs && resp_cnt_q == BLK_W'(NUM_BLOCKS-1)) state_d = EV_SEND;  // line in memory
      end
      EV_SEND: begin
        if (desc_q.op == OP_FLUSH) begin
          flush_done_o = 1'b1;                 // drop it, never shown downstream
          desc_ready_o = 1'b1;
        end else begin
          desc_valid_o = 1'b1;
          desc_ready_o = desc_ready_i;         // refill as soon as it leaves
        end
        if (desc_ready_o) state_d = EV_IDLE;
      end
      default: state_d = EV_IDLE;
    endcase
    // a new descriptor overrides the idle step
    if (take_desc) state_d = (desc_i.op == OP_EVICT) ? EV_EVICT : EV_SEND;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= EV_IDLE;
      req_cnt_q  <= '0;
      wr_cnt_q   <= '0;
      resp_cnt_q <= '0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_cnt) begin
        req_cnt_q  <= '0;
        wr_cnt_q   <= '0;
        resp_cnt_q <= '0;
      end else begin
        if (way_o.req && way_o.gnt) req_cnt_q <= req_cnt_q + 1'b1;
        if (blk_done) wr_cnt_q <= wr_cnt_q + 1'b1;
        if (b_hs) resp_cnt_q <= resp_cnt_q + 1'b1;
      end
      // remember which channel is through until the block completes
      if (blk_done) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q | aw_hs;
        w_done_q  <= w_done_q | w_hs;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (fifo_push) push_ptr_q <= push_ptr_q + 1'b1;
      if (fifo_pop) pop_ptr_q <= pop_ptr_q + 1'b1;
      fifo_cnt_q <= fifo_cnt_q + {{BLK_W{1'b0}}, fifo_push} - {{BLK_W{1'b0}}, fifo_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push) fifo_q[push_ptr_q] <= way_o.rdata;
    if (take_desc) desc_q <= desc_i;
  end

endmodule

// ==== logic/hit_unit.sv ====
`timescale 1ns/1ps

module hit_unit import llc_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  desc_t             desc_i,
  input  logic              desc_valid_i,
  output logic              desc_ready_o,
  way_if.requester          way_o,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              rd_valid_o,
  input  logic              rd_ready_i
);

  desc_t             desc_q;
  logic              busy_q;       // access waiting for the array
  logic              rd_valid_q;   // read result pending toward the top
  logic [DATA_W-1:0] rd_hold_q;    // read word kept while the consumer stalls
  logic              is_write;

  assign is_write = (desc_q.op == OP_WRITE);  // read and evict both read block 0

  // one access at a time, a stalled read result blocks new descriptors
  assign desc_ready_o = ~busy_q & ~rd_valid_q;

  assign way_o.req   = busy_q;
  assign way_o.we    = is_write;
  assign way_o.way   = desc_q.way;
  assign way_o.set   = desc_q.set;
  assign way_o.blk   = '0;
  assign way_o.wdata = desc_q.wdata;

  // fresh word straight from the array, held copy afterwards
  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = way_o.rvalid ? way_o.rdata : rd_hold_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      if (desc_ready_o && desc_valid_i) busy_q <= 1'b1;
      else if (way_o.gnt) busy_q <= 1'b0;
      if (way_o.gnt && !is_write) rd_valid_q <= 1'b1;  // data shows up next cycle
      else if (rd_ready_i) rd_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_ready_o && desc_valid_i) desc_q <= desc_i;
    if (way_o.rvalid) rd_hold_q <= way_o.rdata;
  end

endmodule

// ==== logic/llc_evict_top.sv ====
`timescale 1ns/1ps

module llc_evict_top import llc_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // descriptor input
  input  desc_op_e            desc_op_i,
  input  logic [WAY_W-1:0]    desc_way_i,
  input  logic [SET_W-1:0]    desc_set_i,
  input  logic [ADDR_W-1:0]   desc_addr_i,
  input  logic [DATA_W-1:0]   desc_wdata_i,
  input  logic                desc_valid_i,
  output logic                desc_ready_o,
  // hit results
  output logic [DATA_W-1:0]   rd_data_o,
  output logic                rd_valid_o,
  input  logic                rd_ready_i,
  output logic                flush_done_o,
  // AXI4-Lite write master
  output logic [ADDR_W-1:0]   awaddr_o,
  output logic                awvalid_o,
  input  logic                awready_i,
  output logic [DATA_W-1:0]   wdata_o,
  output logic [DATA_W/8-1:0] wstrb_o,
  output logic                wvalid_o,
  input  logic                wready_i,
  input  logic                bvalid_i,
  output logic                bready_o
);

  desc_t desc_in;                           // packed top level descriptor
  desc_t ev_desc;                           // eviction unit to hit unit
  logic  ev_valid, ev_ready;

  way_if req_way [2] ();                    // one channel per requester
  way_if arr_way ();                        // arbiter to data array

  assign desc_in = '{op: desc_op_i, way: desc_way_i, set: desc_set_i,
                     line_addr: desc_addr_i, wdata: desc_wdata_i};

  evict_unit evict_unit_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .desc_i       (desc_in),
    .desc_valid_i (desc_valid_i),
    .desc_ready_o (desc_ready_o),
    .desc_o       (ev_desc),
    .desc_valid_o (ev_valid),
    .desc_ready_i (ev_ready),
    .way_o        (req_way[REQ_EVICT]),
    .awaddr_o     (awaddr_o),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o),
    .flush_done_o (flush_done_o)
  );

  hit_unit hit_unit_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .desc_i       (ev_desc),
    .desc_valid_i (ev_valid),
    .desc_ready_o (ev_ready),
    .way_o        (req_way[REQ_HIT]),
    .rd_data_o    (rd_data_o),
    .rd_valid_o   (rd_valid_o),
    .rd_ready_i   (rd_ready_i)
  );

  way_arbiter way_arbiter_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .evict_i  (req_way[REQ_EVICT]),
    .hit_i    (req_way[REQ_HIT]),
    .way_o    (arr_way)
  );

  data_way data_way_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .way_i    (arr_way)
  );

endmodule

// ==== logic/llc_pkg.sv ====
package llc_pkg;

  // cache slice geometry
  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 8;
  localparam int NUM_BLOCKS = 4;  // words per line

  // bus and field widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BLK_W  = 2;      // block offset inside a line
  localparam int SET_W  = 3;
  localparam int WAY_W  = 1;

  // operation carried by a descriptor
  typedef enum logic [1:0] {
    OP_READ,                      // read hit, block 0
    OP_WRITE,                     // write hit, block 0
    OP_EVICT,                     // write back whole line, then read block 0
    OP_FLUSH                      // destroyed in the eviction unit
  } desc_op_e;

  // eviction unit states
  typedef enum logic [1:0] {
    EV_IDLE,                      // ready for a new descriptor
    EV_EVICT,                     // array reads and AXI writes in flight
    EV_RESP,                      // all writes out, waiting for B responses
    EV_SEND                       // pass descriptor on or drop a flush
  } evict_state_e;

  // who owns the data array in a given cycle
  typedef enum logic {
    REQ_EVICT,
    REQ_HIT
  } requester_e;

  // descriptor as it travels through the slice
  typedef struct packed {
    desc_op_e           op;
    logic [WAY_W-1:0]   way;
    logic [SET_W-1:0]   set;
    logic [ADDR_W-1:0]  line_addr;  // line aligned memory address
    logic [DATA_W-1:0]  wdata;      // payload for OP_WRITE
  } desc_t;

endpackage

// ==== logic/way_arbiter.sv ====
`timescale 1ns/1ps

module way_arbiter import llc_pkg::*; (
  input logic clk_i,
  input logic arst_n_i,
  way_if.array     evict_i,  // eviction unit side
  way_if.array     hit_i,    // hit unit side
  way_if.requester way_o     // towards the data array
);

  requester_e winner;     // source picked this cycle
  requester_e last_q;     // last source that got the array
  requester_e owner_q;    // source of the access one cycle ago, steers read data

  // round robin, the loser of the last contest goes first
  always_comb begin
    if (evict_i.req && hit_i.req) begin
      winner = (last_q == REQ_EVICT) ? REQ_HIT : REQ_EVICT;
    end else if (hit_i.req) begin
      winner = REQ_HIT;
    end else begin
      winner = REQ_EVICT;
    end
  end

  assign way_o.req   = evict_i.req | hit_i.req;
  assign way_o.we    = (winner == REQ_HIT) ? hit_i.we    : evict_i.we;
  assign way_o.way   = (winner == REQ_HIT) ? hit_i.way   : evict_i.way;
  assign way_o.set   = (winner == REQ_HIT) ? hit_i.set   : evict_i.set;
  assign way_o.blk   = (winner == REQ_HIT) ? hit_i.blk   : evict_i.blk;
  assign way_o.wdata = (winner == REQ_HIT) ? hit_i.wdata : evict_i.wdata;

  // grant only reaches the winner
  assign evict_i.gnt = way_o.gnt & evict_i.req & (winner == REQ_EVICT);
  assign hit_i.gnt   = way_o.gnt & hit_i.req & (winner == REQ_HIT);

  // read data goes back to whoever issued the access
  assign evict_i.rvalid = way_o.rvalid & (owner_q == REQ_EVICT);
  assign hit_i.rvalid   = way_o.rvalid & (owner_q == REQ_HIT);
  assign evict_i.rdata  = way_o.rdata;
  assign hit_i.rdata    = way_o.rdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q  <= REQ_HIT;  // eviction wins the first tie
      owner_q <= REQ_EVICT;
    end else begin
      owner_q <= winner;
      if (way_o.req && way_o.gnt) last_q <= winner;
    end
  end

endmodule

// ==== logic/way_if.sv ====
`timescale 1ns/1ps

// one access channel to the data array
// a request is taken when req and gnt are both high, read data follows one cycle later
interface way_if import llc_pkg::*; ();

  logic              req;     // access request
  logic              we;      // write enable, else read
  logic [WAY_W-1:0]  way;
  logic [SET_W-1:0]  set;
  logic [BLK_W-1:0]  blk;     // word inside the line
  logic [DATA_W-1:0] wdata;
  logic              gnt;     // request taken this cycle
  logic              rvalid;  // read data valid, no back-pressure
  logic [DATA_W-1:0] rdata;

  modport requester (
    output req, we, way, set, blk, wdata,
    input  gnt, rvalid, rdata
  );

  modport array (
    input  req, we, way, set, blk, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// ==== testbench/llc_cases.txt ====
# name op way set line_addr wdata expected, hex except way and set
# expected is the read data for READ and EVICT, unused otherwise
wr_rd_w WRITE 0 1 00001010 a5a50001 00000000
wr_rd_r READ  0 1 00001010 00000000 a5a50001
ev_w    WRITE 1 2 00002000 cafe0002 00000000
ev_r    READ  1 2 00002000 00000000 cafe0002
ev_e    EVICT 1 2 00002000 00000000 cafe0002
fl_f    FLUSH 0 3 00003000 00000000 00000000
bp_w    WRITE 0 4 00004000 b0b00004 00000000
bp_r    READ  0 4 00004000 00000000 b0b00004
bp_e    EVICT 0 4 00004000 00000000 b0b00004
bp_w5   WRITE 1 5 00005000 b0b00005 00000000
bp_r5   READ  1 5 00005000 00000000 b0b00005
bp_r1   READ  0 1 00001010 00000000 a5a50001
bp_w6   WRITE 0 6 00006000 b0b00006 00000000
bp_r6   READ  0 6 00006000 00000000 b0b00006
ar_w0   WRITE 0 7 00007000 d00d0070 00000000
ar_w1   WRITE 1 7 00007100 d00d0171 00000000
ar_r0   READ  0 7 00007000 00000000 d00d0070
ar_r1   READ  1 7 00007100 00000000 d00d0171
ar_e0   EVICT 0 7 00007000 00000000 d00d0070
ar_e1   EVICT 1 7 00007100 00000000 d00d0171
ar_w2   WRITE 0 2 00002100 d00d0022 00000000
ar_e2   EVICT 1 2 00002000 00000000 cafe0002
ar_r2   READ  0 2 00002100 00000000 d00d0022
ar_e3   EVICT 0 7 00007000 00000000 d00d0070

// ==== testbench/tb_llc_evict.sv ====
`timescale 1ns/1ps

module tb_llc_evict import llc_pkg::*; ();

  logic                clk_i;
  logic                arst_n_i;
  desc_op_e            desc_op_i;
  logic [WAY_W-1:0]    desc_way_i;
  logic [SET_W-1:0]    desc_set_i;
  logic [ADDR_W-1:0]   desc_addr_i;
  logic [DATA_W-1:0]   desc_wdata_i;
  logic                desc_valid_i;
  logic                desc_ready_o;
  logic [DATA_W-1:0]   rd_data_o;
  logic                rd_valid_o;
  logic                rd_ready_i;
  logic                flush_done_o;
  logic [ADDR_W-1:0]   awaddr_o;
  logic                awvalid_o;
  logic                awready_i;
  logic [DATA_W-1:0]   wdata_o;
  logic [DATA_W/8-1:0] wstrb_o;
  logic                wvalid_o;
  logic                wready_i;
  logic                bvalid_i;
  logic                bready_o;

  // one entry per line of the cases file
  string               c_name [$];
  desc_op_e            c_op [$];
  int                  c_way [$], c_set [$];
  logic [ADDR_W-1:0]   c_addr [$];
  logic [DATA_W-1:0]   c_wdata [$], c_exp [$];
  bit                  c_err [$];

  logic [DATA_W-1:0]   ref_blk0 [NUM_WAYS][NUM_SETS];  // hits only touch block 0, rest stays zero
  logic [DATA_W-1:0]   mem_model [logic [ADDR_W-1:0]]; // memory behind the AXI port
  int                  rd_q [$];                       // read and evict cases owed a read result
  int                  flush_q [$];
  logic [ADDR_W-1:0]   exp_addr [$];                   // write-backs still to come, in order
  logic [DATA_W-1:0]   exp_data [$];
  int                  exp_case [$];
  logic [ADDR_W-1:0]   aw_q [$];                       // AW and W taken but not yet paired
  logic [DATA_W-1:0]   w_q [$];
  int                  b_pending;                      // responses owed to the DUT
  bit                  b_taken;
  bit                  slow;                           // back-pressure mode on the AXI side
  integer              seed;
  int                  n_cases, n_done, n_err;

  llc_evict_top llc_evict_top_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .desc_op_i    (desc_op_i),
    .desc_way_i   (desc_way_i),
    .desc_set_i   (desc_set_i),
    .desc_addr_i  (desc_addr_i),
    .desc_wdata_i (desc_wdata_i),
    .desc_valid_i (desc_valid_i),
    .desc_ready_o (desc_ready_o),
    .rd_data_o    (rd_data_o),
    .rd_valid_o   (rd_valid_o),
    .rd_ready_i   (rd_ready_i),
    .flush_done_o (flush_done_o),
    .awaddr_o     (awaddr_o),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  function automatic desc_op_e op_from_name(string s);
    case (s)
      "WRITE": return OP_WRITE;
      "EVICT": return OP_EVICT;
      "FLUSH": return OP_FLUSH;
      default: return OP_READ;
    endcase
  endfunction

  // ready draws, mostly high normally and mostly low in back-pressure mode
  function automatic bit draw_ready();
    if (slow) return (($random(seed) & 3) == 0);
    return (($random(seed) & 3) != 0);
  endfunction

  task automatic note_failure(string msg);
    $display("error: %s", msg);
    n_err++;
  endtask

  task automatic flag_mismatch(int idx, string what, logic [DATA_W-1:0] exp_v,
                               logic [DATA_W-1:0] act_v);
    $display("ERR %s %s: expected %h, actual %h", c_name[idx], what, exp_v, act_v);
    c_err[idx] = 1'b1;
    n_err++;
  endtask

  task automatic finish_case(int idx);
    n_done++;
    if (c_err[idx]) $display("test %-8s FAIL", c_name[idx]);
    else $display("test %-8s ok", c_name[idx]);
  endtask

  task automatic load_cases();
    integer            fd;
    string             line, name, opname;
    int                way, set, n;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata, exp_v;
    fd = $fopen("testbench/llc_cases.txt", "r");
    if (fd == 0) begin
      note_failure("cannot open testbench/llc_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 0) != "#") begin  // skip blanks and column notes
          n = $sscanf(line, "%s %s %d %d %h %h %h", name, opname, way, set, addr, wdata, exp_v);
          if (n == 7) begin
            c_name.push_back(name);
            c_op.push_back(op_from_name(opname));
            c_way.push_back(way);
            c_set.push_back(set);
            c_addr.push_back(addr);
            c_wdata.push_back(wdata);
            c_exp.push_back(exp_v);
            c_err.push_back(1'b0);
          end else begin
            note_failure("malformed line in cases file");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // descriptor accepted, predict what it owes
  task automatic record_accept(int idx);
    logic [DATA_W-1:0] word;
    case (c_op[idx])
      OP_WRITE: begin
        ref_blk0[c_way[idx]][c_set[idx]] = c_wdata[idx];
        finish_case(idx);                      // effect shows up in later reads
      end
      OP_READ: rd_q.push_back(idx);
      OP_EVICT: begin
        for (int k = 0; k < NUM_BLOCKS; k++) begin
          word = (k == 0) ? ref_blk0[c_way[idx]][c_set[idx]] : '0;
          exp_addr.push_back(c_addr[idx] + 4 * k);  // block k at line_addr + 4k
          exp_data.push_back(word);
          exp_case.push_back(idx);
        end
        rd_q.push_back(idx);                   // hit unit reads block 0 afterwards
      end
      default: flush_q.push_back(idx);
    endcase
  endtask

  task automatic check_write(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
    int idx;
    b_pending++;
    mem_model[addr] = data;
    if (exp_addr.size() == 0) begin
      note_failure($sformatf("unexpected AXI write of %h to %h", data, addr));
    end else begin
      idx = exp_case.pop_front();
      if (addr != exp_addr[0]) flag_mismatch(idx, "awaddr", exp_addr[0], addr);
      if (data != exp_data[0]) flag_mismatch(idx, "wdata", exp_data[0], data);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  task automatic check_read();
    int                idx;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] want, got;
    if (rd_q.size() == 0) begin
      note_failure("read data returned with no read or evict pending");
    end else begin
      idx = rd_q.pop_front();
      if (rd_data_o !== c_exp[idx]) flag_mismatch(idx, "rd_data", c_exp[idx], rd_data_o);
      if (c_op[idx] == OP_EVICT) begin
        if (exp_case.size() != 0 && exp_case[0] == idx) begin
          note_failure($sformatf("%s passed on before all write-backs", c_name[idx]));
          c_err[idx] = 1'b1;
        end
        for (int k = 0; k < NUM_BLOCKS; k++) begin
          a    = c_addr[idx] + 4 * k;
          want = (k == 0) ? c_exp[idx] : '0;
          got  = mem_model.exists(a) ? mem_model[a] : 'x;
          if (got !== want) flag_mismatch(idx, "memory word", want, got);
        end
      end
      finish_case(idx);
    end
  endtask

  task automatic check_flush();
    if (flush_q.size() == 0) note_failure("flush_done_o pulsed with no flush pending");
    else finish_case(flush_q.pop_front());
  endtask

  // monitor, mid-cycle so all outputs are settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (rd_valid_o && rd_ready_i) check_read();
      if (flush_done_o) check_flush();
      if (awvalid_o && awready_i) aw_q.push_back(awaddr_o);
      if (wvalid_o && wready_i) begin
        w_q.push_back(wdata_o);
        if (wstrb_o != '1) note_failure("wstrb_o not all ones on a write");
      end
      while (aw_q.size() != 0 && w_q.size() != 0) check_write(aw_q.pop_front(), w_q.pop_front());
      if (bvalid_i && bready_o) begin
        b_pending--;
        b_taken = 1'b1;                        // bvalid may drop or move on
      end
    end
  end

  // AXI slave and read consumer, random stalls
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      awready_i  <= draw_ready();
      wready_i   <= draw_ready();
      rd_ready_i <= (($random(seed) & 1) == 1);
      if (!bvalid_i || b_taken) bvalid_i <= (b_pending > 0) && draw_ready();  // hold until taken
      b_taken = 1'b0;
    end
  end

  initial begin
    bit    taken;
    string tag;
    seed         = 30;
    arst_n_i     = 1'b0;
    desc_op_i    = OP_READ;
    desc_way_i   = '0;
    desc_set_i   = '0;
    desc_addr_i  = '0;
    desc_wdata_i = '0;
    desc_valid_i = 1'b0;
    rd_ready_i   = 1'b0;
    awready_i    = 1'b0;
    wready_i     = 1'b0;
    bvalid_i     = 1'b0;
    b_pending    = 0;
    b_taken      = 1'b0;
    slow         = 1'b0;
    n_done       = 0;
    n_err        = 0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) ref_blk0[w][s] = '0;  // array clears on reset
    end
    load_cases();
    n_cases = c_name.size();
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int i = 0; i < n_cases; i++) begin
      tag           = c_name[i];
      slow         <= (tag.substr(0, 1) == "bp");
      desc_op_i    <= c_op[i];
      desc_way_i   <= WAY_W'(c_way[i]);
      desc_set_i   <= SET_W'(c_set[i]);
      desc_addr_i  <= c_addr[i];
      desc_wdata_i <= c_wdata[i];
      desc_valid_i <= 1'b1;
      do begin
        @(negedge clk_i);
        taken = desc_ready_o;                  // transfer happens on the next edge
        @(posedge clk_i);
      end while (!taken);
      record_accept(i);
    end
    desc_valid_i <= 1'b0;
    while (rd_q.size() != 0 || flush_q.size() != 0 || exp_addr.size() != 0) @(posedge clk_i);
    repeat (20) @(posedge clk_i);              // room for stray reads or writes
    if (n_cases == 0 || n_done != n_cases) note_failure("not every test completed");
    $display("%0d tests, %0d completed, %0d errors", n_cases, n_done, n_err);
    if (n_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, 200 cycles per test
  initial begin
    wait (n_cases > 0);
    repeat (n_cases * 200) @(posedge clk_i);
    $display("error: timeout after %0d cycles, DUT stopped responding", n_cases * 200);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/llc_pkg.sv
logic/way_if.sv
logic/data_way.sv
logic/way_arbiter.sv
logic/evict_unit.sv
logic/hit_unit.sv
logic/llc_evict_top.sv
testbench/tb_llc_evict.sv
